// File: common/csr_index_params.svh
`ifndef CSR_INDEX_PARAMS_SVH
`define CSR_INDEX_PARAMS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
// One index or one packet data field
`define CSR_DATA_W 32
// One-hot module ID in the packet destination
`define CSR_MODULE_W 8
// Memory request byte address
`define CSR_ADDR_W 48
// Configuration tag, wraps
`define CSR_TAG_W 8

// ------------------------------------------------------------
// Engine constants
// ------------------------------------------------------------
// Bit position of this engine in the module ID
`define CSR_INDEX_MODULE_ID 2
// Entries in the configuration queue
`define CSR_CONFIG_FIFO_DEPTH 16
// Base of the index array in memory
`define CSR_INDEX_BASE_ADDR 48'h0000_8000_0000
// Four bytes per index entry
`define CSR_INDEX_SHIFT 2

`endif

// File: common/csr_index_pkg.sv
`include "csr_index_params.svh"

package csr_index_pkg;

    // ------------------------------------------------------------
    // Engine response packets
    // ------------------------------------------------------------
    // Destination plus two data words
    // field[0] is the start index, field[1] the array size
    typedef struct packed {
        logic [`CSR_MODULE_W-1:0]     id_module;
        logic [1:0][`CSR_DATA_W-1:0]  field;
    } engine_packet_payload_t;

    // Valid-only stream, no back-pressure
    typedef struct packed {
        logic                    valid;
        engine_packet_payload_t  payload;
    } engine_packet_t;

    // ------------------------------------------------------------
    // Index range configuration
    // ------------------------------------------------------------
    // End is exclusive, start plus size
    typedef struct packed {
        logic [`CSR_DATA_W-1:0]  index_start;
        logic [`CSR_DATA_W-1:0]  index_end;
        logic [`CSR_DATA_W-1:0]  array_size;
    } csr_index_config_t;

    // ------------------------------------------------------------
    // Memory read request
    // ------------------------------------------------------------
    typedef struct packed {
        // Byte address of the index entry
        logic [`CSR_ADDR_W-1:0]  address;
        logic [`CSR_DATA_W-1:0]  index;
        // Which configuration this request belongs to
        logic [`CSR_TAG_W-1:0]   tag;
        // Final index of the configuration
        logic                    last;
    } mem_request_t;

endpackage

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps
`include "csr_index_params.svh"

module sync_fifo #(
    parameter type payload_t = logic [`CSR_DATA_W-1:0],
    parameter int  DEPTH     = `CSR_CONFIG_FIFO_DEPTH
) (
    input  logic      ap_clk,
    input  logic      areset_csr_index_generator,
    input  logic      wr_en,
    input  payload_t  din,
    input  logic      rd_en,
    output payload_t  dout,
    output logic      valid,
    output logic      full,
    output logic      empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage array
    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Writes while full are dropped
    assign do_wr = wr_en & ~full;
    // Pops while empty are ignored
    assign do_rd = rd_en & ~empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // First word falls through
    assign dout  = mem[rd_ptr];
    assign valid = ~empty;

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // Wrap at DEPTH even when not a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Data write
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// File: csr_index_generator/csr_index_configure_engine.sv
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_configure_engine (
    input  logic                              ap_clk,
    input  logic                              areset_csr_index_generator,
    input  csr_index_pkg::engine_packet_t     engine_in,
    input  logic                              cfg_ready,
    output csr_index_pkg::csr_index_config_t  cfg_out,
    output logic                              cfg_valid,
    output logic                              fifo_setup
);

    // Input stage
    csr_index_pkg::engine_packet_t    in_q;
    // Filter stage, only packets for this module
    csr_index_pkg::engine_packet_t    filt_q;
    // Build stage
    logic                             build_valid;
    csr_index_pkg::csr_index_config_t build_cfg;

    logic fifo_rst_q;
    logic cfg_push;
    logic cfg_pop;
    logic fifo_empty;

    // ------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            in_q.valid <= 1'b0;
        end else begin
            in_q.valid <= engine_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_q.payload <= engine_in.payload;
    end

    // ------------------------------------------------------------
    // Module ID filter
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            filt_q.valid <= 1'b0;
        end else begin
            // Exact match against the one-hot ID
            filt_q.valid <= in_q.valid &
                (in_q.payload.id_module == `CSR_MODULE_W'(1 << `CSR_INDEX_MODULE_ID));
        end
    end

    always_ff @(posedge ap_clk) begin
        filt_q.payload <= in_q.payload;
    end

    // ------------------------------------------------------------
    // Configuration build
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            build_valid <= 1'b0;
        end else begin
            build_valid <= filt_q.valid;
        end
    end

    // Start from field 0, size from field 1, end exclusive
    always_ff @(posedge ap_clk) begin
        build_cfg.index_start <= filt_q.payload.field[0];
        build_cfg.index_end   <= filt_q.payload.field[0] + filt_q.payload.field[1];
        build_cfg.array_size  <= filt_q.payload.field[1];
    end

    // ------------------------------------------------------------
    // Configuration queue
    // ------------------------------------------------------------
    // Empty ranges never reach the queue
    assign cfg_push = build_valid & (|build_cfg.array_size);
    assign cfg_pop  = cfg_ready & ~fifo_empty;

    sync_fifo #(
        .payload_t (csr_index_pkg::csr_index_config_t),
        .DEPTH     (`CSR_CONFIG_FIFO_DEPTH)
    ) u_cfg_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .wr_en                      (cfg_push),
        .din                        (build_cfg),
        .rd_en                      (cfg_pop),
        .dout                       (cfg_out),
        .valid                      (cfg_valid),
        .full                       (),
        .empty                      (fifo_empty)
    );

    // ------------------------------------------------------------
    // Setup flag
    // ------------------------------------------------------------
    // Held through reset and one more cycle
    always_ff @(posedge ap_clk) begin
        fifo_rst_q <= areset_csr_index_generator;
        if (areset_csr_index_generator) begin
            fifo_setup <= 1'b1;
        end else begin
            fifo_setup <= fifo_rst_q;
        end
    end

endmodule

// File: csr_index_generator/csr_index_generator_fsm.sv
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_generator_fsm (
    input  logic                   ap_clk,
    input  logic                   areset_csr_index_generator,
    input  logic                   cfg_valid,
    input  logic                   idx_valid,
    input  logic                   idx_last,
    input  logic                   idx_ready,
    output logic                   cfg_ready,
    output logic                   cnt_load,
    output logic [`CSR_TAG_W-1:0]  tag
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        RUN
    } state_t;

    state_t state;
    state_t state_next;
    logic   last_xfer;

    // Final index of the range accepted downstream
    assign last_xfer = idx_valid & idx_ready & idx_last;

    // Pop and load share one cycle, the head is still on the FIFO output
    assign cfg_ready = (state == LOAD);
    assign cnt_load  = (state == LOAD) & cfg_valid;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cfg_valid) begin
                    state_next = LOAD;
                end
            end
            LOAD: begin
                state_next = RUN;
            end
            RUN: begin
                // One range in flight at a time
                if (last_xfer) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // State and tag registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state <= IDLE;
            tag   <= '0;
        end else begin
            state <= state_next;
            // Next range gets the next tag, wraps naturally
            if (state == RUN && last_xfer) begin
                tag <= tag + 1'b1;
            end
        end
    end

endmodule

// File: csr_index_generator/csr_index_counter.sv
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_counter (
    input  logic                              ap_clk,
    input  logic                              areset_csr_index_generator,
    input  logic                              cnt_load,
    input  csr_index_pkg::csr_index_config_t  cfg_in,
    input  logic                              idx_ready,
    output logic [`CSR_DATA_W-1:0]            index,
    output logic                              idx_valid,
    output logic                              idx_last
);

    // Exclusive end of the current range
    logic [`CSR_DATA_W-1:0] index_end;

    // Next step reaches the end
    assign idx_last = idx_valid & ((index + 1'b1) == index_end);

    // ------------------------------------------------------------
    // Valid flag
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            idx_valid <= 1'b0;
        end else if (cnt_load) begin
            // Queue holds only nonzero sizes
            idx_valid <= 1'b1;
        end else if (idx_valid && idx_ready && idx_last) begin
            idx_valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Index walk
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cnt_load) begin
            index     <= cfg_in.index_start;
            index_end <= cfg_in.index_end;
        end else if (idx_valid && idx_ready) begin
            // Stalls in place while not accepted
            index <= index + 1'b1;
        end
    end

endmodule

// File: csr_index_generator/csr_index_request_builder.sv
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_request_builder (
    input  logic                          ap_clk,
    input  logic                          areset_csr_index_generator,
    input  logic [`CSR_DATA_W-1:0]        index,
    input  logic                          idx_valid,
    input  logic                          idx_last,
    input  logic [`CSR_TAG_W-1:0]         tag,
    input  logic                          req_ready,
    output logic                          idx_ready,
    output csr_index_pkg::mem_request_t   req_out,
    output logic                          req_valid
);

    logic [`CSR_ADDR_W-1:0] index_ext;
    logic                   take;

    // Register empty or draining this cycle, so one per cycle
    assign idx_ready = ~req_valid | req_ready;
    assign take      = idx_valid & idx_ready;

    // Zero extend before scaling to bytes
    assign index_ext = {{(`CSR_ADDR_W - `CSR_DATA_W){1'b0}}, index};

    // ------------------------------------------------------------
    // Output valid
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            req_valid <= 1'b0;
        end else if (take) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Request payload
    // ------------------------------------------------------------
    // Held while stalled
    always_ff @(posedge ap_clk) begin
        if (take) begin
            req_out.address <= `CSR_INDEX_BASE_ADDR + (index_ext << `CSR_INDEX_SHIFT);
            req_out.index   <= index;
            req_out.tag     <= tag;
            req_out.last    <= idx_last;
        end
    end

endmodule

// File: rtl/csr_index_generator_top.sv
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_generator_top (
    input  logic                           ap_clk,
    input  logic                           areset_csr_index_generator,
    input  csr_index_pkg::engine_packet_t  engine_in,
    input  logic                           req_ready,
    output csr_index_pkg::mem_request_t    req_out,
    output logic                           req_valid,
    output logic                           fifo_setup
);

    // ------------------------------------------------------------
    // Interconnect
    // ------------------------------------------------------------
    // Queue head to FSM
    csr_index_pkg::csr_index_config_t cfg_out;
    logic                             cfg_valid;
    logic                             cfg_ready;

    // FSM to counter
    logic                   cnt_load;
    logic [`CSR_TAG_W-1:0]  tag;

    // Counter to builder
    logic [`CSR_DATA_W-1:0] index;
    logic                   idx_valid;
    logic                   idx_last;
    logic                   idx_ready;

    // Filter, build and queue
    csr_index_configure_engine u_cfg_engine (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .engine_in                  (engine_in),
        .cfg_ready                  (cfg_ready),
        .cfg_out                    (cfg_out),
        .cfg_valid                  (cfg_valid),
        .fifo_setup                 (fifo_setup)
    );

    // One range at a time, tags per range
    csr_index_generator_fsm u_fsm (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .cfg_valid                  (cfg_valid),
        .idx_valid                  (idx_valid),
        .idx_last                   (idx_last),
        .idx_ready                  (idx_ready),
        .cfg_ready                  (cfg_ready),
        .cnt_load                   (cnt_load),
        .tag                        (tag)
    );

    // Walks start up to end
    csr_index_counter u_counter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .cnt_load                   (cnt_load),
        .cfg_in                     (cfg_out),
        .idx_ready                  (idx_ready),
        .index                      (index),
        .idx_valid                  (idx_valid),
        .idx_last                   (idx_last)
    );

    // Memory request output stage
    csr_index_request_builder u_builder (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .index                      (index),
        .idx_valid                  (idx_valid),
        .idx_last                   (idx_last),
        .tag                        (tag),
        .req_ready                  (req_ready),
        .idx_ready                  (idx_ready),
        .req_out                    (req_out),
        .req_valid                  (req_valid)
    );

endmodule

// File: tests/csr_index_generator_chk.sv
`timescale 1ns/1ps

module csr_index_generator_chk (
    input logic                        ap_clk,
    input logic                        areset_csr_index_generator,
    input logic                        req_valid,
    input logic                        req_ready,
    input csr_index_pkg::mem_request_t req_out,
    input logic                        cfg_push,
    input logic                        cfg_full
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Request held until the consumer takes it
    property p_req_stable;
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
            (req_valid && !req_ready) |=> (req_valid && $stable(req_out));
    endproperty

    // Output register cleared by reset
    property p_reset_idle;
        @(posedge ap_clk) areset_csr_index_generator |=> !req_valid;
    endproperty

    // Queue must never overflow since the input has no back-pressure
    property p_no_overflow;
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
            !(cfg_push && cfg_full);
    endproperty

    a_req_stable: assert property (p_req_stable)
        else begin
            fail_count++;
            $error("request changed or dropped while stalled");
        end
    a_reset_idle: assert property (p_reset_idle)
        else begin
            fail_count++;
            $error("req_valid high right after reset");
        end
    a_no_overflow: assert property (p_no_overflow)
        else begin
            fail_count++;
            $error("configuration queue written while full");
        end

endmodule

// File: tests/csr_index_generator_tb.sv
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_generator_tb;

    // One-hot destination of this engine and of a neighbour
    localparam logic [`CSR_MODULE_W-1:0] OWN_ID   = `CSR_MODULE_W'(1) << `CSR_INDEX_MODULE_ID;
    localparam logic [`CSR_MODULE_W-1:0] OTHER_ID = OWN_ID << 1;
    localparam int WAIT_LIMIT = 400;

    logic                          ap_clk;
    logic                          areset_csr_index_generator;
    csr_index_pkg::engine_packet_t engine_in;
    logic                          req_ready;
    csr_index_pkg::mem_request_t   req_out;
    logic                          req_valid;
    logic                          fifo_setup;

    // Scoreboard of requests still to come, in order
    csr_index_pkg::mem_request_t exp_q[$];
    csr_index_pkg::mem_request_t exp_head;
    logic [`CSR_TAG_W-1:0]       next_tag;
    logic [15:0]                 lfsr_state;
    string                       test_name;

    csr_index_generator_top uut (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .engine_in                  (engine_in),
        .req_ready                  (req_ready),
        .req_out                    (req_out),
        .req_valid                  (req_valid),
        .fifo_setup                 (fifo_setup)
    );

    // Handshake and queue assertions inside the DUT
    bind csr_index_generator_top csr_index_generator_chk u_chk (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .req_valid                  (req_valid),
        .req_ready                  (req_ready),
        .req_out                    (req_out),
        .cfg_push                   (u_cfg_engine.cfg_push),
        .cfg_full                   (u_cfg_engine.u_cfg_fifo.full)
    );

    // 40 ns period
    always #20 ap_clk = ~ap_clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One step per bit taken
    function automatic logic random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // Expected requests of one range
    // Tag advances only for a nonzero size
    task automatic expect_config(input logic [31:0] start, input logic [31:0] size);
        csr_index_pkg::mem_request_t r;
        logic [31:0] k;
        for (k = '0; k < size; k++) begin
            r.index   = start + k;
            r.address = `CSR_INDEX_BASE_ADDR + (`CSR_ADDR_W'(r.index) * `CSR_ADDR_W'(4));
            r.tag     = next_tag;
            r.last    = (k == size - 1);
            exp_q.push_back(r);
        end
        if (size != 0) begin
            next_tag = next_tag + 1'b1;
        end
    endtask

    // Valid for one cycle from a falling edge
    task automatic send_packet(input logic [`CSR_MODULE_W-1:0] id, input logic [31:0] start,
                               input logic [31:0] size);
        engine_in.valid            = 1'b1;
        engine_in.payload.id_module = id;
        engine_in.payload.field[0] = start;
        engine_in.payload.field[1] = size;
        @(negedge ap_clk);
        engine_in.valid = 1'b0;
    endtask

    // Run until the scoreboard is empty and the output idle
    task automatic drain_requests(input bit random_ready);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || req_valid) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timeout in %s: %0d requests never arrived", test_name, exp_q.size());
                $display("Result: FAILED");
                $fatal(1, "drain timeout");
            end else begin
                req_ready = random_ready ? random_bit() : 1'b1;
                @(negedge ap_clk);
                cycles++;
            end
        end
        req_ready = 1'b1;
    endtask

    // Window in which no request may appear
    task automatic quiet_cycles(input int n);
        repeat (n) @(negedge ap_clk);
    endtask

    // ------------------------------------------------------------
    // Response monitor
    // ------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (!areset_csr_index_generator && req_valid && req_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected request for index 0x%0h in %s", req_out.index, test_name);
                $display("Result: FAILED");
                $fatal(1, "unexpected request");
            end else begin
                exp_head = exp_q.pop_front();
                check_value("address", 64'(exp_head.address), 64'(req_out.address));
                check_value("index", 64'(exp_head.index), 64'(req_out.index));
                check_value("tag", 64'(exp_head.tag), 64'(req_out.tag));
                check_value("last", 64'(exp_head.last), 64'(req_out.last));
            end
        end
    end

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    // Setup flag spans reset plus one cycle
    task automatic test_reset();
        test_name = "reset";
        areset_csr_index_generator = 1'b1;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        check_value("fifo_setup in reset", 64'(1), 64'(fifo_setup));
        check_value("req_valid in reset", 64'(0), 64'(req_valid));
        areset_csr_index_generator = 1'b0;
        @(negedge ap_clk);
        check_value("fifo_setup after release", 64'(1), 64'(fifo_setup));
        @(negedge ap_clk);
        check_value("fifo_setup settled", 64'(0), 64'(fifo_setup));
        check_value("req_valid idle", 64'(0), 64'(req_valid));
    endtask

    task automatic test_single_config();
        test_name = "single_config";
        expect_config(32'd5, 32'd4);
        send_packet(OWN_ID, 32'd5, 32'd4);
        drain_requests(1'b0);
    endtask

    // Foreign ID and empty range are dropped and keep the tag
    task automatic test_filtered();
        test_name = "filtered";
        send_packet(OTHER_ID, 32'd100, 32'd3);
        send_packet(OWN_ID, 32'd200, 32'd0);
        quiet_cycles(30);
        expect_config(32'd40, 32'd2);
        send_packet(OWN_ID, 32'd40, 32'd2);
        drain_requests(1'b0);
    endtask

    task automatic test_back_to_back();
        test_name = "back_to_back";
        expect_config(32'd0, 32'd3);
        expect_config(32'd1000, 32'd5);
        expect_config(32'd77, 32'd1);
        send_packet(OWN_ID, 32'd0, 32'd3);
        send_packet(OWN_ID, 32'd1000, 32'd5);
        send_packet(OWN_ID, 32'd77, 32'd1);
        drain_requests(1'b0);
    endtask

    // Consumer stalls at random
    task automatic test_backpressure();
        test_name = "backpressure";
        expect_config(32'd200, 32'd20);
        send_packet(OWN_ID, 32'd200, 32'd20);
        drain_requests(1'b1);
    endtask

    initial begin
        ap_clk                     = 1'b0;
        areset_csr_index_generator = 1'b1;
        engine_in                  = '0;
        req_ready                  = 1'b1;
        next_tag                   = '0;
        lfsr_state                 = 16'd36;
        test_name                  = "init";
        test_reset();
        test_single_config();
        test_filtered();
        test_back_to_back();
        test_backpressure();
        quiet_cycles(20);
        if (uut.u_chk.fail_count != 0) begin
            $display("%0d assertions failed in the bound checker", uut.u_chk.fail_count);
            $display("Result: FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: csr_index_generator_top.f
+incdir+common
common/csr_index_pkg.sv
rtl/sync_fifo.sv
csr_index_generator/csr_index_configure_engine.sv
csr_index_generator/csr_index_generator_fsm.sv
csr_index_generator/csr_index_counter.sv
csr_index_generator/csr_index_request_builder.sv
rtl/csr_index_generator_top.sv
tests/csr_index_generator_chk.sv
tests/csr_index_generator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the CSR index generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_index_generator_tb \
    -f csr_index_generator_top.f \
    --Mdir obj_dir -o csr_index_generator_sim

status=0
./obj_dir/csr_index_generator_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
else
    echo "simulation did not pass (exit status $status)"
    exit 1
fi
